// ==== src/axi_rd_pkg.sv ====
package axi_rd_pkg;

    //////////////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 4;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int DATA_W  = 32;
    localparam int RESP_W  = 2;

    // AR and R field types
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [ID_W-1:0]    id_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [SIZE_W-1:0]  size_t;
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [RESP_W-1:0]  resp_t;

    localparam burst_t BURST_INCR = 2'b01;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // lowest address bit of the 4K page number
    localparam int PAGE_LSB = 12;

    // one locally answered request
    typedef struct packed {
        id_t  id;
        len_t len;
    } err_rec_t;

endpackage

// ==== src/xbar_map_pkg.sv ====
package xbar_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // slave side of the crossbar
    //////////////////////////////////////////////////////////////////////
    localparam int SLV_NB = 3;

    typedef logic [SLV_NB-1:0] slv_vec_t;

    // inclusive address windows, one per slave
    localparam axi_rd_pkg::addr_t SLV_START [SLV_NB] = '{
        32'd0,
        32'd4096,
        32'd8192
    };

    localparam axi_rd_pkg::addr_t SLV_END [SLV_NB] = '{
        32'd4095,
        32'd8191,
        32'd12287
    };

    // slaves this master may reach
    localparam slv_vec_t MST_ROUTES = '1;

    // outstanding locally answered reads
    localparam int ERR_DEPTH = 4;
    localparam int ERR_PTR_W = $clog2(ERR_DEPTH);

endpackage

// ==== src/rd_err_if.sv ====
`timescale 1ns/1ps

interface rd_err_if;
    import axi_rd_pkg::*;

    logic     valid;
    logic     ready;
    err_rec_t rec;

    // producer side
    modport src (
        output valid,
        output rec,
        input  ready
    );

    modport snk (
        input  valid,
        input  rec,
        output ready
    );
endinterface

// ==== src/ar_decoder.sv ====
`timescale 1ns/1ps

module ar_decoder (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   i_arvalid,
    output logic                   o_arready,
    input  axi_rd_pkg::addr_t      i_araddr,
    input  axi_rd_pkg::len_t       i_arlen,
    input  axi_rd_pkg::size_t      i_arsize,
    input  axi_rd_pkg::burst_t     i_arburst,
    input  axi_rd_pkg::id_t        i_arid,
    output xbar_map_pkg::slv_vec_t o_s_arvalid,
    input  xbar_map_pkg::slv_vec_t i_s_arready,
    rd_err_if.src                  err_in
);
    import axi_rd_pkg::*;
    import xbar_map_pkg::*;

    slv_vec_t hit;
    addr_t    last_addr;
    logic     cross_4k;
    logic     fwd;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // disabled routes never hit
    for (genvar k = 0; k < SLV_NB; k++) begin : g_win
        assign hit[k] = MST_ROUTES[k]
                     && (i_araddr >= SLV_START[k])
                     && (i_araddr <= SLV_END[k]);
    end

    // address of the last byte of the burst
    assign last_addr = i_araddr + (addr_t'(i_arlen) << i_arsize);

    // only INCR bursts walk across pages
    assign cross_4k = (i_arburst == BURST_INCR)
                   && (i_araddr[ADDR_W-1:PAGE_LSB] != last_addr[ADDR_W-1:PAGE_LSB]);

    assign fwd = (|hit) && !cross_4k;

    //////////////////////////////////////////////////////////////////////
    // AR steering
    //////////////////////////////////////////////////////////////////////

    assign o_s_arvalid = {SLV_NB{i_arvalid && fwd}} & hit;

    // error requests are taken as soon as the record fits
    always_comb begin
        o_arready = 1'b0;
        if (i_arvalid) begin
            if (fwd) begin
                o_arready = |(hit & i_s_arready);
            end else begin
                o_arready = err_in.ready;
            end
        end
    end

    // misroute or 4K crossing becomes a record
    assign err_in.valid   = i_arvalid && !fwd;
    assign err_in.rec.id  = i_arid;
    assign err_in.rec.len = i_arlen;

    // windows in the map must not overlap
    a_hit_onehot : assert property (
        @(posedge aclk) disable iff (!aresetn)
        $onehot0(hit)
    ) else $error("address %h hits more than one slave window", i_araddr);

endmodule

// ==== src/err_fifo.sv ====
`timescale 1ns/1ps

module err_fifo (
    input  logic  aclk,
    input  logic  aresetn,
    rd_err_if.snk err_in,
    rd_err_if.src err_out
);
    import axi_rd_pkg::*;
    import xbar_map_pkg::*;

    err_rec_t             mem [ERR_DEPTH];
    logic [ERR_PTR_W-1:0] wr_ptr;
    logic [ERR_PTR_W-1:0] rd_ptr;
    logic [ERR_PTR_W:0]   count;
    logic                 push;
    logic                 pop;

    assign push = err_in.valid && err_in.ready;
    assign pop  = err_out.valid && err_out.ready;

    assign err_in.ready  = (count != (ERR_PTR_W + 1)'(ERR_DEPTH));
    assign err_out.valid = (count != '0);
    assign err_out.rec   = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= err_in.rec;
        end
    end

    // pointers wrap on their own
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound : assert property (
        @(posedge aclk) disable iff (!aresetn)
        count <= (ERR_PTR_W + 1)'(ERR_DEPTH)
    ) else $error("error FIFO count %0d above depth", count);

endmodule

// ==== src/r_merger.sv ====
`timescale 1ns/1ps

module r_merger (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  xbar_map_pkg::slv_vec_t i_s_rvalid,
    input  xbar_map_pkg::slv_vec_t i_s_rlast,
    input  axi_rd_pkg::id_t        i_s_rid   [xbar_map_pkg::SLV_NB],
    input  axi_rd_pkg::data_t      i_s_rdata [xbar_map_pkg::SLV_NB],
    input  axi_rd_pkg::resp_t      i_s_rresp [xbar_map_pkg::SLV_NB],
    output xbar_map_pkg::slv_vec_t o_s_rready,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output axi_rd_pkg::id_t        o_rid,
    output axi_rd_pkg::data_t      o_rdata,
    output axi_rd_pkg::resp_t      o_rresp,
    output logic                   o_rlast,
    rd_err_if.snk                  err_out
);
    import axi_rd_pkg::*;
    import xbar_map_pkg::*;

    slv_vec_t grant;
    slv_vec_t last_grant;
    slv_vec_t nxt_grant;
    len_t     beat_cnt;
    logic     err_sel;
    logic     err_last;
    logic     slv_last_hs;

    //////////////////////////////////////////////////////////////////////
    // source selection
    //////////////////////////////////////////////////////////////////////

    // a pending record owns the output whenever no slave is granted
    assign err_sel  = (grant == '0) && err_out.valid;
    assign err_last = (beat_cnt == err_out.rec.len);

    // round robin from the slave after the last one served
    always_comb begin
        int base;
        int idx;
        base      = SLV_NB - 1;
        nxt_grant = '0;
        for (int k = 0; k < SLV_NB; k++) begin
            if (last_grant[k]) begin
                base = k;
            end
        end
        for (int off = 1; off <= SLV_NB; off++) begin
            idx = (base + off) % SLV_NB;
            if (nxt_grant == '0 && i_s_rvalid[idx]) begin
                nxt_grant[idx] = 1'b1;
            end
        end
    end

    assign slv_last_hs = (grant != '0) && o_rvalid && i_rready && o_rlast;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            grant      <= '0;
            last_grant <= '0;
        end else if (slv_last_hs) begin
            grant <= '0;
        end else if (grant == '0 && !err_out.valid && nxt_grant != '0) begin
            grant      <= nxt_grant;
            last_grant <= nxt_grant;
        end
    end

    // beats of the DECERR burst
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (err_sel && i_rready) begin
            beat_cnt <= err_last ? '0 : beat_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // R channel mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        o_rvalid = 1'b0;
        o_rid    = '0;
        o_rdata  = '0;
        o_rresp  = RESP_OKAY;
        o_rlast  = 1'b0;
        if (err_sel) begin
            o_rvalid = 1'b1;
            o_rid    = err_out.rec.id;
            o_rresp  = RESP_DECERR;
            o_rlast  = err_last;
        end else begin
            for (int k = 0; k < SLV_NB; k++) begin
                if (grant[k]) begin
                    o_rvalid = i_s_rvalid[k];
                    o_rid    = i_s_rid[k];
                    o_rdata  = i_s_rdata[k];
                    o_rresp  = i_s_rresp[k];
                    o_rlast  = i_s_rlast[k];
                end
            end
        end
    end

    assign o_s_rready    = grant & {SLV_NB{i_rready}};
    assign err_out.ready = err_sel && i_rready && err_last;

    // at most one slave granted
    a_grant_onehot : assert property (
        @(posedge aclk) disable iff (!aresetn)
        $onehot0(grant)
    ) else $error("more than one R source selected");

    a_r_stable : assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rid) && $stable(o_rdata)
                                 && $stable(o_rresp) && $stable(o_rlast)
    ) else $error("R beat changed while stalled");

endmodule

// ==== src/mst_rd_switch.sv ====
`timescale 1ns/1ps

module mst_rd_switch (
    input  logic                   aclk,
    input  logic                   aresetn,

    // master AR
    input  logic                   i_arvalid,
    output logic                   o_arready,
    input  axi_rd_pkg::addr_t      i_araddr,
    input  axi_rd_pkg::id_t        i_arid,
    input  axi_rd_pkg::len_t       i_arlen,
    input  axi_rd_pkg::size_t      i_arsize,
    input  axi_rd_pkg::burst_t     i_arburst,

    // master R
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output axi_rd_pkg::id_t        o_rid,
    output axi_rd_pkg::data_t      o_rdata,
    output axi_rd_pkg::resp_t      o_rresp,
    output logic                   o_rlast,

    // slave AR, fields shared by all slaves
    output xbar_map_pkg::slv_vec_t o_s_arvalid,
    input  xbar_map_pkg::slv_vec_t i_s_arready,
    output axi_rd_pkg::addr_t      o_s_araddr,
    output axi_rd_pkg::id_t        o_s_arid,
    output axi_rd_pkg::len_t       o_s_arlen,
    output axi_rd_pkg::size_t      o_s_arsize,
    output axi_rd_pkg::burst_t     o_s_arburst,

    // slave R
    input  xbar_map_pkg::slv_vec_t i_s_rvalid,
    output xbar_map_pkg::slv_vec_t o_s_rready,
    input  xbar_map_pkg::slv_vec_t i_s_rlast,
    input  axi_rd_pkg::id_t        i_s_rid   [xbar_map_pkg::SLV_NB],
    input  axi_rd_pkg::data_t      i_s_rdata [xbar_map_pkg::SLV_NB],
    input  axi_rd_pkg::resp_t      i_s_rresp [xbar_map_pkg::SLV_NB]
);

    rd_err_if err_in ();
    rd_err_if err_out ();

    assign o_s_araddr  = i_araddr;
    assign o_s_arid    = i_arid;
    assign o_s_arlen   = i_arlen;
    assign o_s_arsize  = i_arsize;
    assign o_s_arburst = i_arburst;

    ar_decoder u_dec (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .i_araddr    (i_araddr),
        .i_arlen     (i_arlen),
        .i_arsize    (i_arsize),
        .i_arburst   (i_arburst),
        .i_arid      (i_arid),
        .o_s_arvalid (o_s_arvalid),
        .i_s_arready (i_s_arready),
        .err_in      (err_in.src)
    );

    err_fifo u_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .err_in  (err_in.snk),
        .err_out (err_out.src)
    );

    r_merger u_merger (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_s_rvalid (i_s_rvalid),
        .i_s_rlast  (i_s_rlast),
        .i_s_rid    (i_s_rid),
        .i_s_rdata  (i_s_rdata),
        .i_s_rresp  (i_s_rresp),
        .o_s_rready (o_s_rready),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rid      (o_rid),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp),
        .o_rlast    (o_rlast),
        .err_out    (err_out.snk)
    );

endmodule

// ==== sim/tb_mst_rd_switch.sv ====
`timescale 1ns/1ps

module tb_mst_rd_switch;
    import axi_rd_pkg::*;
    import xbar_map_pkg::*;

    localparam int CLK_NS  = 4;
    localparam int RST_CYC = 16;
    localparam int ERR_SRC = SLV_NB;
    // cycle budget of each test in run order
    localparam int BUDGET [6] = '{300, 400, 300, 300, 6000, 600};

    logic     aclk;
    logic     aresetn;
    logic     i_arvalid;
    logic     o_arready;
    addr_t    i_araddr;
    id_t      i_arid;
    len_t     i_arlen;
    size_t    i_arsize;
    burst_t   i_arburst;
    logic     o_rvalid;
    logic     i_rready = 1'b0;
    id_t      o_rid;
    data_t    o_rdata;
    resp_t    o_rresp;
    logic     o_rlast;
    slv_vec_t o_s_arvalid;
    slv_vec_t i_s_arready = '0;
    addr_t    o_s_araddr;
    id_t      o_s_arid;
    len_t     o_s_arlen;
    size_t    o_s_arsize;
    burst_t   o_s_arburst;
    slv_vec_t i_s_rvalid = '0;
    slv_vec_t o_s_rready;
    slv_vec_t i_s_rlast = '0;
    id_t      i_s_rid   [SLV_NB] = '{default: '0};
    data_t    i_s_rdata [SLV_NB] = '{default: '0};
    resp_t    i_s_rresp [SLV_NB] = '{default: RESP_OKAY};

    err_rec_t slv_q [SLV_NB][$];
    err_rec_t exp_q [SLV_NB+1][$];
    int       slv_beat [SLV_NB] = '{default: 0};
    int       exp_src;
    slv_vec_t exp_vec;
    err_rec_t cur;
    int       cur_src;
    int       beat;
    logic     in_burst = 1'b0;
    int       rr_mode = 1;
    int       bursts_done = 0;
    int       errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       err_at_start;
    string    test_name = "reset";

    mst_rd_switch uut (.*);

    //////////////////////////////////////////////////////////////////////
    // reference routing
    //////////////////////////////////////////////////////////////////////

    // 4 KB windows from 0 and a misroute past the third
    function automatic int route_of(addr_t addr, len_t len, size_t size, burst_t burst);
        addr_t last;
        last = addr + (addr_t'(len) << size);
        if (addr >= 32'd12288) begin
            return ERR_SRC;
        end
        if (burst == BURST_INCR && (addr >> 12) != (last >> 12)) begin
            return ERR_SRC;
        end
        return int'(addr >> 12);
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int s = 0; s <= ERR_SRC; s++) begin
            n += exp_q[s].size();
        end
        return n;
    endfunction

    assign exp_src = route_of(i_araddr, i_arlen, i_arsize, i_arburst);
    assign exp_vec = (exp_src == ERR_SRC) ? '0 : slv_vec_t'(1 << exp_src);

    task automatic report_mismatch(string field, logic [31:0] exp_v, logic [31:0] act_v);
        errors++;
        $display("MISMATCH %s %s expected %0h actual %0h", test_name, field, exp_v, act_v);
    endtask

    a_route : assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid |-> o_s_arvalid == exp_vec
    ) else report_mismatch("s_arvalid", 32'(exp_vec), 32'(o_s_arvalid));

    a_fwd_ready : assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid && exp_vec != '0 |-> o_arready == |(exp_vec & i_s_arready)
    ) else report_mismatch("arready", 32'(|(exp_vec & i_s_arready)), 32'(o_arready));

    // shared slave AR fields carry the master request
    a_s_addr : assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid |-> o_s_araddr == i_araddr
    ) else report_mismatch("s_araddr", i_araddr, o_s_araddr);

    a_s_ctrl : assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid |-> {o_s_arid, o_s_arlen, o_s_arsize, o_s_arburst}
                      == {i_arid, i_arlen, i_arsize, i_arburst}
    ) else report_mismatch("s_ar fields", 32'({i_arid, i_arlen, i_arsize, i_arburst}),
                           32'({o_s_arid, o_s_arlen, o_s_arsize, o_s_arburst}));

    // one master beat against the head of its source queue
    task automatic check_beat();
        data_t exp_data;
        if (!in_burst) begin
            cur_src = (o_rresp == RESP_DECERR) ? ERR_SRC : int'(o_rdata[23:16]);
            if (cur_src > ERR_SRC || exp_q[cur_src].size() == 0) begin
                errors++;
                $display("%s: R burst from source %0d with no request outstanding",
                         test_name, cur_src);
                return;
            end
            cur      = exp_q[cur_src][0];
            in_burst = 1'b1;
            beat     = 0;
        end
        exp_data = (cur_src == ERR_SRC) ? '0 : {8'h00, 8'(cur_src), 8'(cur.id), 8'(beat)};
        assert (o_rid == cur.id) else report_mismatch("rid", 32'(cur.id), 32'(o_rid));
        assert (o_rdata == exp_data) else report_mismatch("rdata", exp_data, o_rdata);
        assert (o_rresp == ((cur_src == ERR_SRC) ? RESP_DECERR : RESP_OKAY))
            else report_mismatch("rresp", 32'((cur_src == ERR_SRC) ? 3 : 0), 32'(o_rresp));
        assert (o_rlast == (beat == int'(cur.len)))
            else report_mismatch("rlast", 32'(beat == int'(cur.len)), 32'(o_rlast));
        if (beat == int'(cur.len)) begin
            void'(exp_q[cur_src].pop_front());
            in_burst = 1'b0;
            bursts_done++;
        end else begin
            beat++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // handshake monitor and slave models
    //////////////////////////////////////////////////////////////////////
    always @(posedge aclk) begin
        if (aresetn) begin
            if (i_arvalid && o_arready) begin
                exp_q[exp_src].push_back(err_rec_t'({i_arid, i_arlen}));
            end
            for (int k = 0; k < SLV_NB; k++) begin
                if (o_s_arvalid[k] && i_s_arready[k]) begin
                    slv_q[k].push_back(err_rec_t'({o_s_arid, o_s_arlen}));
                end
                if (i_s_rvalid[k] && o_s_rready[k]) begin
                    if (slv_beat[k] == int'(slv_q[k][0].len)) begin
                        slv_beat[k] = 0;
                        void'(slv_q[k].pop_front());
                    end else begin
                        slv_beat[k]++;
                    end
                end
            end
            if (o_rvalid && i_rready) begin
                check_beat();
            end
        end
    end

    // valid stays up until its beat is taken
    always @(negedge aclk) begin
        for (int k = 0; k < SLV_NB; k++) begin
            i_s_arready[k] <= aresetn && ($urandom % 3 != 0);
            if (aresetn && slv_q[k].size() > 0 && (i_s_rvalid[k] || $urandom % 2 == 0)) begin
                i_s_rvalid[k] <= 1'b1;
                i_s_rid[k]    <= slv_q[k][0].id;
                i_s_rdata[k]  <= {8'h00, 8'(k), 8'(slv_q[k][0].id), 8'(slv_beat[k])};
                i_s_rlast[k]  <= (slv_beat[k] == int'(slv_q[k][0].len));
            end else begin
                i_s_rvalid[k] <= 1'b0;
            end
        end
        case (rr_mode)
            0:       i_rready <= 1'b0;
            1:       i_rready <= 1'b1;
            default: i_rready <= ($urandom % 3 != 0);
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic drive_ar(addr_t addr, id_t id, len_t len, size_t size, burst_t burst);
        @(negedge aclk);
        i_arvalid = 1'b1;
        i_araddr  = addr;
        i_arid    = id;
        i_arlen   = len;
        i_arsize  = size;
        i_arburst = burst;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!o_arready && n < 200);
        if (!o_arready) begin
            errors++;
            $display("%s: request at %h not accepted within 200 cycles", test_name, i_araddr);
        end
        @(negedge aclk);
        i_arvalid = 1'b0;
    endtask

    task automatic issue(addr_t addr, id_t id, len_t len, size_t size, burst_t burst);
        drive_ar(addr, id, len, size, burst);
        wait_accept();
    endtask

    task automatic set_rready(int mode);
        @(posedge aclk);
        rr_mode = mode;
    endtask

    task automatic start_test(string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test(int idx);
        int n;
        n = 0;
        while ((outstanding() != 0 || in_burst) && n < BUDGET[idx]) begin
            @(negedge aclk);
            n++;
        end
        if (n >= BUDGET[idx]) begin
            errors++;
            $display("%s: %0d bursts still outstanding after %0d cycles",
                     test_name, outstanding(), n);
        end
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, errors - err_at_start);
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #(CLK_NS / 2) aclk = ~aclk;
    end

    initial begin
        int total;
        total = RST_CYC;
        foreach (BUDGET[i]) begin
            total += BUDGET[i];
        end
        #(total * 2 * CLK_NS);
        $display("watchdog: run did not finish within %0d cycles", total * 2);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int done_before;
        void'($urandom(32'h25f3_1ffd));
        aresetn   = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arid    = '0;
        i_arlen   = '0;
        i_arsize  = '0;
        i_arburst = BURST_INCR;
        repeat (RST_CYC) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        start_test("routing");
        issue(32'h0000_0100, 4'd1, 4'd3, 3'd2, BURST_INCR);
        issue(32'h0000_1100, 4'd2, 4'd3, 3'd2, BURST_INCR);
        issue(32'h0000_2100, 4'd3, 4'd3, 3'd2, BURST_INCR);
        issue(32'h0000_0ffc, 4'd4, 4'd0, 3'd2, BURST_INCR);
        issue(32'h0000_2ffc, 4'd5, 4'd0, 3'd2, BURST_INCR);
        end_test(0);

        start_test("read_data");
        issue(32'h0000_0000, 4'd5, 4'd15, 3'd2, BURST_INCR);
        issue(32'h0000_1800, 4'd6, 4'd0, 3'd0, BURST_INCR);
        issue(32'h0000_2000, 4'd7, 4'd7, 3'd1, BURST_INCR);
        end_test(1);

        start_test("misroute");
        issue(32'h0000_3000, 4'd8, 4'd2, 3'd2, BURST_INCR);
        issue(32'hffff_f000, 4'd9, 4'd0, 3'd2, BURST_INCR);
        issue(32'h8000_0004, 4'd10, 4'd15, 3'd2, BURST_INCR);
        end_test(2);

        // same fields once as INCR and once as FIXED
        start_test("cross_4k");
        issue(32'h0000_0ff0, 4'd11, 4'd7, 3'd2, BURST_INCR);
        issue(32'h0000_0ff0, 4'd12, 4'd7, 3'd2, 2'b00);
        issue(32'h0000_1ffe, 4'd13, 4'd1, 3'd1, BURST_INCR);
        end_test(3);

        start_test("no_interleave");
        set_rready(2);
        for (int n = 0; n < 40; n++) begin
            issue(addr_t'(($urandom % 14) * 1024 + ($urandom % 256) * 4), id_t'($urandom),
                  len_t'($urandom), size_t'($urandom % 3), burst_t'($urandom % 2));
        end
        end_test(4);

        start_test("back_pressure");
        set_rready(0);
        for (int n = 0; n < ERR_DEPTH; n++) begin
            issue(32'h0001_0000, id_t'(n), 4'd1, 3'd2, BURST_INCR);
        end
        drive_ar(32'h0001_0000, 4'd4, 4'd1, 3'd2, BURST_INCR);
        repeat (8) begin
            @(posedge aclk);
            assert (!o_arready) else report_mismatch("arready", 32'd0, 32'(o_arready));
        end
        done_before = bursts_done;
        set_rready(1);
        wait_accept();
        assert (bursts_done > done_before)
            else report_mismatch("bursts done", 32'(done_before + 1), 32'(bursts_done));
        end_test(5);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/axi_rd_pkg.sv
src/xbar_map_pkg.sv
src/rd_err_if.sv
src/ar_decoder.sv
src/err_fifo.sv
src/r_merger.sv
src/mst_rd_switch.sv
sim/tb_mst_rd_switch.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mst_rd_switch -f list.f -o sim_tb \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
